// File: design/nmr_seq_pkg.sv
// sequence timing types; all durations count pulseprog_clk cycles and must be at least 1
package nmr_seq_pkg;

	// ============================================================
	// scalar types
	// ============================================================

	typedef logic [31:0] cycle_cnt_t;	// duration in clock cycles
	typedef logic [15:0] echo_cnt_t;	// echoes per scan

	// ============================================================
	// parameter set, loaded once per run
	// ============================================================

	// 6 x 32 + 16 + 1 + 15 = 224 bits
	typedef struct packed {
		cycle_cnt_t	pulse90;			// 90 deg excitation width
		cycle_cnt_t	delay_nosig;		// dead time after the 90 deg pulse
		cycle_cnt_t	pulse180;			// refocusing pulse width
		cycle_cnt_t	delay_sig;			// listening delay after each 180
		cycle_cnt_t	rx_delay;			// window offset inside delay_sig
		cycle_cnt_t	samples_per_echo;	// window length
		echo_cnt_t	echoes;				// number of 180/listen pairs
		logic		phase_cycle;		// 1 flips the sign of I and Q
		logic [14:0]	spare;			// reserved, keep zero
	} seq_param_t;

	// ============================================================
	// sequencer FSM
	// ============================================================

	typedef enum logic [2:0] {
		IDLE,		// waiting for run_start
		P90,		// tx on, first pulse
		DLY_NOSIG,	// tx off, receiver blanked
		P180,		// tx on, refocusing
		DLY_SIG		// receiver on, window inside
	} seq_state_t;

endpackage

// File: design/nmr_acq_pkg.sv
// acquisition types; ADC is 14-bit offset binary, dc_sub is expected to lie within the ADC range
package nmr_acq_pkg;

	// ============================================================
	// sample and sum widths
	// ============================================================

	typedef logic [13:0]		adc_word_t;	// raw unsigned ADC code
	typedef logic signed [14:0]	iq_word_t;	// one bit wider, after dc removal
	typedef logic signed [23:0]	acc_t;		// group sum, 255 x 15 bit fits
	typedef logic [7:0]			dec_fact_t;	// samples per group, 1..255

	// acquisition settings, 23 bits
	typedef struct packed {
		iq_word_t	dc_sub;		// value subtracted from every sample
		dec_fact_t	dec_fact;	// group size
	} acq_param_t;

	// ============================================================
	// data path words
	// ============================================================

	// one decimated result, 48 bits
	typedef struct packed {
		acc_t	i_sum;
		acc_t	q_sum;
	} iq_sample_t;

	// one mixed sample, 30 bits
	typedef struct packed {
		iq_word_t	i;
		iq_word_t	q;
	} iq_pair_t;

endpackage

// File: design/param_loader.sv
// settings are captured at ack rise; samples still in the ADC latency pipe after busy falls see new ones
module param_loader
(
	input	logic						pulseprog_clk,
	input	logic						arst_n,

	// host side, four-phase
	input	logic						param_req,
	output	logic						param_ack,
	input	nmr_seq_pkg::seq_param_t	seq_param,
	input	nmr_acq_pkg::acq_param_t	acq_param,

	// run control
	input	logic						busy_in,	// sequencer running
	output	logic						run_start,	// one cycle, ends the handshake
	output	nmr_seq_pkg::seq_param_t	seq_cfg,
	output	nmr_acq_pkg::acq_param_t	acq_cfg
);

	logic	can_load;	// no run active or about to start
	logic	load;		// capture this cycle

	assign can_load = !busy_in && !run_start;
	assign load     = param_req && !param_ack && can_load;

	// handshake control
	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			param_ack <= 1'b0;
			run_start <= 1'b0;
		end
		else
		begin
			run_start <= 1'b0;				// default, pulse only
			if (load)
				param_ack <= 1'b1;			// phase 2
			else if (param_ack && !param_req)
			begin
				param_ack <= 1'b0;			// phase 4
				run_start <= 1'b1;			// kick the sequencer
			end
		end
	end

	// config registers, held for the whole run
	always_ff @(posedge pulseprog_clk)
	begin
		if (load)
		begin
			seq_cfg <= seq_param;
			acq_cfg <= acq_param;
		end
	end

endmodule

// File: design/cpmg_sequencer.sv
// CPMG timing; every duration and echoes must be at least 1, ADC_LATENCY at least 1
module cpmg_sequencer
#(
	parameter int ADC_LATENCY = 5	// ADC pipeline depth in clocks
)
(
	input	logic						pulseprog_clk,
	input	logic						arst_n,

	input	logic						run_start,
	input	nmr_seq_pkg::seq_param_t	seq_cfg,

	output	logic						tx_gate,		// rf transmit on
	output	logic						rx_en,			// receiver on
	output	logic						busy,			// run in progress
	output	logic						sample_strobe,	// adc word valid now
	output	logic						win_first		// first strobe of a window
);

	// ============================================================
	// state and counters
	// ============================================================

	nmr_seq_pkg::seq_state_t	state;
	nmr_seq_pkg::cycle_cnt_t	cnt;		// cycles spent in the current state
	nmr_seq_pkg::cycle_cnt_t	cur_len;	// length of the current state
	nmr_seq_pkg::echo_cnt_t		echo_cnt;	// echoes done
	logic						state_done;
	logic						last_echo;

	always_comb
	begin
		unique case (state)
			nmr_seq_pkg::P90:		cur_len = seq_cfg.pulse90;
			nmr_seq_pkg::DLY_NOSIG:	cur_len = seq_cfg.delay_nosig;
			nmr_seq_pkg::P180:		cur_len = seq_cfg.pulse180;
			nmr_seq_pkg::DLY_SIG:	cur_len = seq_cfg.delay_sig;
			default:				cur_len = '0;	// idle, not timed
		endcase
	end

	assign state_done = (cnt == cur_len - nmr_seq_pkg::cycle_cnt_t'(1));
	assign last_echo  = (echo_cnt == seq_cfg.echoes - nmr_seq_pkg::echo_cnt_t'(1));

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= nmr_seq_pkg::IDLE;
			cnt      <= '0;
			echo_cnt <= '0;
		end
		else if (state == nmr_seq_pkg::IDLE)
		begin
			cnt      <= '0;
			echo_cnt <= '0;
			if (run_start)
				state <= nmr_seq_pkg::P90;	// pulse begins next cycle
		end
		else if (!state_done)
			cnt <= cnt + nmr_seq_pkg::cycle_cnt_t'(1);
		else
		begin
			cnt <= '0;
			unique case (state)
				nmr_seq_pkg::P90:		state <= nmr_seq_pkg::DLY_NOSIG;
				nmr_seq_pkg::DLY_NOSIG:	state <= nmr_seq_pkg::P180;
				nmr_seq_pkg::P180:		state <= nmr_seq_pkg::DLY_SIG;
				default:
				begin
					// end of a listening delay
					echo_cnt <= echo_cnt + nmr_seq_pkg::echo_cnt_t'(1);
					state    <= last_echo ? nmr_seq_pkg::IDLE : nmr_seq_pkg::P180;
				end
			endcase
		end
	end

	// decoded straight from state
	assign tx_gate = (state == nmr_seq_pkg::P90) || (state == nmr_seq_pkg::P180);
	assign rx_en   = (state == nmr_seq_pkg::DLY_SIG);
	assign busy    = (state != nmr_seq_pkg::IDLE);

	// ============================================================
	// acquisition window
	// ============================================================

	logic [32:0]	win_end;	// rx_delay + samples, one bit of headroom
	logic			window;
	logic			win_start;

	assign win_end   = {1'b0, seq_cfg.rx_delay} + {1'b0, seq_cfg.samples_per_echo};
	assign window    = rx_en && (cnt >= seq_cfg.rx_delay) && ({1'b0, cnt} < win_end);
	assign win_start = window && (cnt == seq_cfg.rx_delay);	// cut short by delay end anyway

	// ============================================================
	// latency alignment
	// ============================================================

	// several windows' worth of strobes can be in flight
	logic [ADC_LATENCY-1:0]	win_sr;
	logic [ADC_LATENCY-1:0]	first_sr;

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			win_sr   <= '0;
			first_sr <= '0;
		end
		else
		begin
			for (int i = ADC_LATENCY - 1; i > 0; i--)
			begin
				win_sr[i]   <= win_sr[i-1];
				first_sr[i] <= first_sr[i-1];
			end
			win_sr[0]   <= window;
			first_sr[0] <= win_start;
		end
	end

	assign sample_strobe = win_sr[ADC_LATENCY-1];	// window + ADC_LATENCY
	assign win_first     = first_sr[ADC_LATENCY-1];

endmodule

// File: design/iq_demod.sv
// quarter-rate mixer without filter; -16384 after dc removal does not negate cleanly
module iq_demod
(
	input	logic						pulseprog_clk,
	input	logic						arst_n,

	input	logic						sample_strobe,
	input	logic						win_first,		// restart the phase
	input	nmr_acq_pkg::adc_word_t		adc_data,
	input	nmr_acq_pkg::iq_word_t		dc_sub,
	input	logic						phase_cycle,	// invert both outputs

	output	nmr_acq_pkg::iq_pair_t		pair,
	output	logic						pair_valid,
	output	logic						pair_first		// win_first, one cycle later
);

	nmr_acq_pkg::iq_word_t	s;			// sample minus dc
	nmr_acq_pkg::iq_word_t	mag;		// s with sign applied
	logic [1:0]				phase_k;	// index of the next strobe, mod 4
	logic [1:0]				k_cur;		// index used this strobe
	logic					neg;

	assign s     = $signed({1'b0, adc_data}) - dc_sub;
	assign k_cur = win_first ? 2'd0 : phase_k;
	assign neg   = k_cur[1] ^ phase_cycle;	// k = 2,3 negative, flipped by phase cycling
	assign mag   = neg ? -s : s;

	// control
	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase_k    <= '0;
			pair_valid <= 1'b0;
			pair_first <= 1'b0;
		end
		else
		begin
			pair_valid <= sample_strobe;
			pair_first <= sample_strobe && win_first;
			if (sample_strobe)
				phase_k <= k_cur + 2'd1;
		end
	end

	// payload, even k on I, odd k on Q
	always_ff @(posedge pulseprog_clk)
	begin
		if (sample_strobe)
		begin
			pair.i <= k_cur[0] ? nmr_acq_pkg::iq_word_t'(0) : mag;
			pair.q <= k_cur[0] ? mag : nmr_acq_pkg::iq_word_t'(0);
		end
	end

endmodule

// File: design/iq_decimator.sv
// group summing with a single result slot; dec_fact 0 is not supported
module iq_decimator
(
	input	logic						pulseprog_clk,
	input	logic						arst_n,

	input	nmr_acq_pkg::iq_pair_t		pair,
	input	logic						pair_valid,
	input	logic						pair_first,	// new window, drop any partial group
	input	nmr_acq_pkg::dec_fact_t		dec_fact,
	input	logic						run_start,	// clears overrun

	// reader side, four-phase
	output	logic						out_req,
	input	logic						out_ack,
	output	nmr_acq_pkg::iq_sample_t	out_data,
	output	logic						overrun		// sticky for the run
);

	// ============================================================
	// accumulation
	// ============================================================

	nmr_acq_pkg::acc_t		acc_i;
	nmr_acq_pkg::acc_t		acc_q;
	nmr_acq_pkg::acc_t		nxt_i;
	nmr_acq_pkg::acc_t		nxt_q;
	nmr_acq_pkg::dec_fact_t	grp_cnt;	// pairs in the open group
	nmr_acq_pkg::dec_fact_t	nxt_cnt;
	logic					grp_done;
	logic					pending;	// slot not free yet

	// a window's first pair starts from zero
	assign nxt_i    = (pair_first ? nmr_acq_pkg::acc_t'(0) : acc_i) + nmr_acq_pkg::acc_t'(pair.i);
	assign nxt_q    = (pair_first ? nmr_acq_pkg::acc_t'(0) : acc_q) + nmr_acq_pkg::acc_t'(pair.q);
	assign nxt_cnt  = (pair_first ? nmr_acq_pkg::dec_fact_t'(0) : grp_cnt) + 8'd1;
	assign grp_done = pair_valid && (nxt_cnt == dec_fact);
	assign pending  = out_req || out_ack;	// offer again only after ack low

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
			grp_cnt <= '0;
		else if (run_start || grp_done)
			grp_cnt <= '0;
		else if (pair_valid)
			grp_cnt <= nxt_cnt;
	end

	always_ff @(posedge pulseprog_clk)
	begin
		if (pair_valid)
		begin
			acc_i <= grp_done ? nmr_acq_pkg::acc_t'(0) : nxt_i;	// next group starts empty
			acc_q <= grp_done ? nmr_acq_pkg::acc_t'(0) : nxt_q;
		end
	end

	// ============================================================
	// output slot and handshake
	// ============================================================

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_req <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			if (run_start)
				overrun <= 1'b0;
			if (grp_done && pending)
				overrun <= 1'b1;			// reader too slow, group lost
			if (grp_done && !pending)
				out_req <= 1'b1;
			else if (out_req && out_ack)
				out_req <= 1'b0;			// phase 3
		end
	end

	always_ff @(posedge pulseprog_clk)
	begin
		if (grp_done && !pending)
			out_data <= '{i_sum: nxt_i, q_sum: nxt_q};
	end

endmodule

// File: design/nmr_pulseprog_top.sv
// acquisition core top; single clock, ADC data must be sampled on pulseprog_clk
module nmr_pulseprog_top
#(
	parameter int ADC_LATENCY = 5	// clocks from window to valid ADC word
)
(
	input	logic						pulseprog_clk,
	input	logic						arst_n,

	// parameter load
	input	logic						param_req,
	output	logic						param_ack,
	input	nmr_seq_pkg::seq_param_t	seq_param,
	input	nmr_acq_pkg::acq_param_t	acq_param,

	// front end
	input	nmr_acq_pkg::adc_word_t		adc_data,
	output	logic						tx_gate,
	output	logic						rx_en,
	output	logic						busy,

	// results
	output	logic						out_req,
	input	logic						out_ack,
	output	nmr_acq_pkg::iq_sample_t	out_data,
	output	logic						overrun
);

	// ============================================================
	// internal nets
	// ============================================================

	logic						run_start;
	nmr_seq_pkg::seq_param_t	seq_cfg;
	nmr_acq_pkg::acq_param_t	acq_cfg;
	logic						sample_strobe;
	logic						win_first;
	nmr_acq_pkg::iq_pair_t		pair;
	logic						pair_valid;
	logic						pair_first;

	param_loader u_param_loader
	(
		.pulseprog_clk	(pulseprog_clk),
		.arst_n			(arst_n),
		.param_req		(param_req),
		.param_ack		(param_ack),
		.seq_param		(seq_param),
		.acq_param		(acq_param),
		.busy_in		(busy),			// no reload while running
		.run_start		(run_start),
		.seq_cfg		(seq_cfg),
		.acq_cfg		(acq_cfg)
	);

	cpmg_sequencer
	#(
		.ADC_LATENCY	(ADC_LATENCY)
	)
	u_cpmg_sequencer
	(
		.pulseprog_clk	(pulseprog_clk),
		.arst_n			(arst_n),
		.run_start		(run_start),
		.seq_cfg		(seq_cfg),
		.tx_gate		(tx_gate),
		.rx_en			(rx_en),
		.busy			(busy),
		.sample_strobe	(sample_strobe),
		.win_first		(win_first)
	);

	iq_demod u_iq_demod
	(
		.pulseprog_clk	(pulseprog_clk),
		.arst_n			(arst_n),
		.sample_strobe	(sample_strobe),
		.win_first		(win_first),
		.adc_data		(adc_data),
		.dc_sub			(acq_cfg.dc_sub),
		.phase_cycle	(seq_cfg.phase_cycle),
		.pair			(pair),
		.pair_valid		(pair_valid),
		.pair_first		(pair_first)
	);

	iq_decimator u_iq_decimator
	(
		.pulseprog_clk	(pulseprog_clk),
		.arst_n			(arst_n),
		.pair			(pair),
		.pair_valid		(pair_valid),
		.pair_first		(pair_first),
		.dec_fact		(acq_cfg.dec_fact),
		.run_start		(run_start),
		.out_req		(out_req),
		.out_ack		(out_ack),
		.out_data		(out_data),
		.overrun		(overrun)
	);

endmodule

// File: bench/tb_nmr_pulseprog.sv
// self-checking bench; reads bench/nmr_stim.txt from the project root, ADC_LATENCY fixed at 5
module tb_nmr_pulseprog;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADC_LATENCY = 5;
	localparam int NUM_TESTS   = 6;
	localparam int WPT         = 27;	// 11 settings + 16 adc codes per test

	// ============================================================
	// DUT and clocking
	// ============================================================

	logic						pulseprog_clk = 1'b0;
	logic						arst_n;
	logic						param_req;
	logic						param_ack;
	nmr_seq_pkg::seq_param_t	seq_param;
	nmr_acq_pkg::acq_param_t	acq_param;
	nmr_acq_pkg::adc_word_t		adc_data;
	logic						tx_gate;
	logic						rx_en;
	logic						busy;
	logic						out_req;
	logic						out_ack;
	nmr_acq_pkg::iq_sample_t	out_data;
	logic						overrun;

	logic [31:0]				stim_mem [0:NUM_TESTS*WPT-1];
	nmr_acq_pkg::iq_sample_t	got_q[$];	// results taken by the reader
	nmr_acq_pkg::iq_sample_t	exp_q[$];	// results from the model
	int							seed = 67376;
	int							cyc = 0;		// clock count
	int							t0 = 0;			// cycle of the first P90 clock
	int							adc_test = 0;	// test whose adc list is driven
	int							offers = 0;		// out_req rising edges
	int							err_count = 0;
	int							limit_cycles = 0;
	logic						req_seen = 1'b0;
	logic						hold_ack = 1'b0;	// reader withholds out_ack

	always #4 pulseprog_clk = ~pulseprog_clk;	// 8 ns period

	nmr_pulseprog_top #(.ADC_LATENCY(ADC_LATENCY)) u_nmr_pulseprog_top
	(
		.pulseprog_clk	(pulseprog_clk),
		.arst_n			(arst_n),
		.param_req		(param_req),
		.param_ack		(param_ack),
		.seq_param		(seq_param),
		.acq_param		(acq_param),
		.adc_data		(adc_data),
		.tx_gate		(tx_gate),
		.rx_en			(rx_en),
		.busy			(busy),
		.out_req		(out_req),
		.out_ack		(out_ack),
		.out_data		(out_data),
		.overrun		(overrun)
	);

	// ============================================================
	// stim access and checks
	// ============================================================

	function automatic logic [31:0] stim_word(input int idx, input int pos);
		return stim_mem[idx * WPT + pos];
	endfunction

	// adc code for a cycle counted from P90 start
	function automatic nmr_acq_pkg::adc_word_t adc_at(input int idx, input int n);
		int pos;
		pos = (n < 0) ? 0 : n % 16;
		return nmr_acq_pkg::adc_word_t'(stim_mem[idx * WPT + 11 + pos]);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_count(input nmr_seq_pkg::cycle_cnt_t got,
		input nmr_seq_pkg::cycle_cnt_t exp, input string what);
		if (got !== exp)
		begin
			err_count++;
			abort_run($sformatf("CHECK FAILED at %0d ns: %s got %0d expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_iq(input nmr_acq_pkg::iq_sample_t got,
		input nmr_acq_pkg::iq_sample_t exp, input string what);
		if (got !== exp)
		begin
			err_count++;
			abort_run($sformatf("CHECK FAILED at %0d ns: %s got (%0d,%0d) expected (%0d,%0d)",
				$time, what, $signed(got.i_sum), $signed(got.q_sum),
				$signed(exp.i_sum), $signed(exp.q_sum)));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			err_count++;
			abort_run($sformatf("CHECK FAILED at %0d ns: %s got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	// ============================================================
	// reference model of demod and decimator
	// ============================================================

	task automatic build_expected(input int idx);
		int p90, dn, p180, ds, rxd, spe, ech, ph, dc, dec;
		int base, k, cnt, si, sq, s;
		p90  = int'(stim_word(idx, 0));
		dn   = int'(stim_word(idx, 1));
		p180 = int'(stim_word(idx, 2));
		ds   = int'(stim_word(idx, 3));
		rxd  = int'(stim_word(idx, 4));
		spe  = int'(stim_word(idx, 5));
		ech  = int'(stim_word(idx, 6));
		ph   = int'(stim_word(idx, 7));
		dc   = int'(nmr_acq_pkg::iq_word_t'(stim_word(idx, 8)));
		dec  = int'(stim_word(idx, 9));
		exp_q.delete();
		for (int e = 0; e < ech; e++)
		begin
			base = p90 + dn + e * (p180 + ds) + p180;	// first DLY_SIG cycle
			k    = 0;
			cnt  = 0;
			si   = 0;
			sq   = 0;	// partial group from last window dropped here
			for (int j = rxd; j < rxd + spe && j < ds; j++)
			begin
				s = int'(adc_at(idx, base + j + ADC_LATENCY)) - dc;
				if (ph != 0)
					s = -s;
				case (k % 4)
					0:			si += s;
					1:			sq += s;
					2:			si -= s;
					default:	sq -= s;
				endcase
				k++;
				cnt++;
				if (cnt == dec)
				begin
					exp_q.push_back('{i_sum: nmr_acq_pkg::acc_t'(si),
						q_sum: nmr_acq_pkg::acc_t'(sq)});
					cnt = 0;
					si  = 0;
					sq  = 0;
				end
			end
		end
	endtask

	// ============================================================
	// host side
	// ============================================================

	task automatic present_params(input int idx);
		nmr_seq_pkg::seq_param_t	sp;
		nmr_acq_pkg::acq_param_t	ap;
		sp.pulse90          = stim_word(idx, 0);
		sp.delay_nosig      = stim_word(idx, 1);
		sp.pulse180         = stim_word(idx, 2);
		sp.delay_sig        = stim_word(idx, 3);
		sp.rx_delay         = stim_word(idx, 4);
		sp.samples_per_echo = stim_word(idx, 5);
		sp.echoes           = nmr_seq_pkg::echo_cnt_t'(stim_word(idx, 6));
		sp.phase_cycle      = (stim_word(idx, 7) != 32'd0);
		sp.spare            = '0;
		ap.dc_sub           = nmr_acq_pkg::iq_word_t'(stim_word(idx, 8));
		ap.dec_fact         = nmr_acq_pkg::dec_fact_t'(stim_word(idx, 9));
		@(posedge pulseprog_clk);
		seq_param <= sp;
		acq_param <= ap;
		param_req <= 1'b1;
	endtask

	// phases 2 to 4, then note where P90 begins
	task automatic finish_load(input int idx);
		int guard;
		guard = 0;
		@(negedge pulseprog_clk);
		while (!param_ack)
		begin
			guard++;
			if (guard > 2000)
				abort_run("param_ack never rose after param_req");
			@(negedge pulseprog_clk);
		end
		@(posedge pulseprog_clk);
		param_req <= 1'b0;
		guard = 0;
		@(negedge pulseprog_clk);
		while (param_ack)
		begin
			guard++;
			if (guard > 10)
				abort_run("param_ack stayed high after param_req fell");
			@(negedge pulseprog_clk);
		end
		t0       = cyc + 1;		// run_start now, P90 next cycle
		adc_test = idx;
	endtask

	// ============================================================
	// one run with all its checks
	// ============================================================

	task automatic run_one(input int idx);
		int		segs[$];
		int		seg, busy_cyc, rx_cyc, mode, ech, guard, offers_base, exp_busy;
		logic	prev_tx;
		logic	req_pending;
		mode        = int'(stim_word(idx, 10));
		ech         = int'(stim_word(idx, 6));
		req_pending = 1'b0;
		hold_ack    = (mode == 2);
		got_q.delete();
		build_expected(idx);
		offers_base = offers;
		if (mode != 1)
			present_params(idx);
		finish_load(idx);
		@(negedge pulseprog_clk);
		check_flag(busy, 1'b1, "busy at P90 start");
		check_flag(overrun, 1'b0, "overrun after run_start");
		prev_tx  = 1'b1;
		seg      = 0;
		busy_cyc = 0;
		rx_cyc   = 0;
		while (busy)
		begin
			busy_cyc++;
			if (rx_en)
				rx_cyc++;
			if (tx_gate == prev_tx)
				seg++;
			else
			begin
				segs.push_back(seg);	// edge of tx_gate
				seg     = 1;
				prev_tx = tx_gate;
			end
			if (req_pending)
				check_flag(param_ack, 1'b0, "param_ack while busy");
			if (busy_cyc == 2 && idx + 1 < NUM_TESTS && int'(stim_word(idx + 1, 10)) == 1)
			begin
				present_params(idx + 1);	// next set asks during this run
				req_pending = 1'b1;
			end
			@(negedge pulseprog_clk);
		end
		segs.push_back(seg);

		// pulse and gap widths
		check_count(nmr_seq_pkg::cycle_cnt_t'(segs.size()),
			nmr_seq_pkg::cycle_cnt_t'(2 + 2 * ech), "tx_gate segment count");
		for (int i = 0; i < segs.size() && i < 2 + 2 * ech; i++)
			check_count(nmr_seq_pkg::cycle_cnt_t'(segs[i]),
				(i < 2) ? stim_word(idx, i) : stim_word(idx, 2 + (i % 2)),
				$sformatf("test %0d tx segment %0d", idx, i));
		exp_busy = int'(stim_word(idx, 0) + stim_word(idx, 1))
			+ ech * int'(stim_word(idx, 2) + stim_word(idx, 3));
		check_count(nmr_seq_pkg::cycle_cnt_t'(busy_cyc),
			nmr_seq_pkg::cycle_cnt_t'(exp_busy), "busy length");
		check_count(nmr_seq_pkg::cycle_cnt_t'(rx_cyc),
			nmr_seq_pkg::cycle_cnt_t'(ech * int'(stim_word(idx, 3))), "rx_en length");

		// let the latency pipe and the reader drain
		repeat (ADC_LATENCY + 12) @(negedge pulseprog_clk);
		if (mode == 2)
		begin
			check_count(nmr_seq_pkg::cycle_cnt_t'(offers - offers_base), 1, "results offered");
			check_flag(out_req, 1'b1, "out_req held");
			check_flag(overrun, 1'b1, "overrun raised");
			if (exp_q.size() > 0)
				check_iq(out_data, exp_q[0], "held result");
			hold_ack = 1'b0;
		end
		guard = 0;
		while ((out_req || out_ack) && guard < 50)
		begin
			guard++;
			@(negedge pulseprog_clk);
		end
		check_flag(out_req || out_ack, 1'b0, "output handshake idle");
		if (mode != 2)
		begin
			check_count(nmr_seq_pkg::cycle_cnt_t'(got_q.size()),
				nmr_seq_pkg::cycle_cnt_t'(exp_q.size()), "result count");
			foreach (exp_q[i])
				check_iq(got_q[i], exp_q[i], $sformatf("test %0d result %0d", idx, i));
			check_flag(overrun, 1'b0, "overrun with a fast reader");
		end
	endtask

	// ============================================================
	// drivers and monitors
	// ============================================================

	always @(posedge pulseprog_clk)
	begin
		cyc      <= cyc + 1;
		adc_data <= adc_at(adc_test, cyc + 1 - t0);	// code for the cycle now starting
	end

	always @(negedge pulseprog_clk)
	begin
		if (out_req && !req_seen)
			offers <= offers + 1;
		req_seen <= out_req;
	end

	// reader with a random ack delay
	initial
	begin : reader
		int d;
		forever
		begin
			@(negedge pulseprog_clk);
			if (out_req && !out_ack && !hold_ack)
			begin
				got_q.push_back(out_data);
				d = $random(seed) & 3;
				repeat (d) @(posedge pulseprog_clk);
				@(posedge pulseprog_clk);
				out_ack <= 1'b1;			// phase 2
				@(negedge pulseprog_clk);
				while (out_req)
					@(negedge pulseprog_clk);
				@(posedge pulseprog_clk);
				out_ack <= 1'b0;			// phase 4
			end
		end
	end

	initial
	begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge pulseprog_clk);
		abort_run("watchdog timeout, the tests did not finish in time");
	end

	initial
	begin : main
		arst_n    = 1'b0;
		param_req = 1'b0;
		seq_param = '0;
		acq_param = '0;
		adc_data  = '0;
		out_ack   = 1'b0;
		stim_mem[NUM_TESTS * WPT - 1] = '1;	// no adc code can look like this
		$readmemh("bench/nmr_stim.txt", stim_mem);
		if (stim_mem[NUM_TESTS * WPT - 1] === '1)
			abort_run("stimulus file bench/nmr_stim.txt missing or short");
		for (int i = 0; i < NUM_TESTS; i++)
			limit_cycles += int'(stim_word(i, 0) + stim_word(i, 1)) + 150
				+ int'(stim_word(i, 6)) * int'(stim_word(i, 2) + stim_word(i, 3));
		limit_cycles += 100;	// reset and margin
		repeat (5) @(posedge pulseprog_clk);
		arst_n <= 1'b1;
		@(negedge pulseprog_clk);
		check_flag(param_ack | tx_gate | rx_en | busy | out_req | overrun, 1'b0,
			"outputs after reset");
		for (int t = 0; t < NUM_TESTS; t++)
			run_one(t);
		if (err_count == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
			abort_run("errors counted at end of run");
	end

endmodule

// File: bench/nmr_stim.txt
// settings: pulse90 delay_nosig pulse180 delay_sig rx_delay samples_per_echo echoes phase_cycle dc_sub dec_fact mode
// then 16 adc codes by cycle since P90 mod 16; mode 0 plain, 1 loaded during the previous run, 2 out_ack held
// test 0, plain CPMG with a partial group per window
4 6 8 28 6 14 3 0 1f40 8 0
2010 1e80 2300 1c00 1f40 2100 1d55 20aa 1fff 1e00 2222 1b00 2400 1f00 2050 1e90
// test 1, phase cycled, window cut off by the end of delay_sig
3 5 6 20 c 20 2 1 1000 8 0
1100 0f00 1234 0e00 1000 1300 0c80 1080 0fff 11aa 0d00 1400 1010 0f80 1200 0e40
// test 2, run during which the next set is requested
5 4 7 30 4 18 4 0 2000 c 0
2100 1f00 2200 1e00 2080 1f80 2333 1ccc 2000 2400 1c00 2111 1eee 2050 1fb0 2222
// test 3, loaded while test 2 is busy
6 5 a 24 2 10 2 1 800 10 1
0900 0700 0a00 0600 0850 07b0 0c00 0400 0800 0880 0780 0a40 05c0 0900 0740 0810
// test 4, reader stalls and overrun rises
3 4 5 20 3 10 2 0 1500 4 2
1600 1400 1700 1300 1580 1480 1800 1200 1500 1650 13b0 1520 14e0 1900 1100 1555
// test 5, normal run after the overrun
2 3 4 1c 1 18 3 0 1800 9 0
1900 1700 1a00 1600 1880 1780 1b00 1500 1800 1950 16b0 1820 17e0 1c00 1400 1855

// File: flist.f
design/nmr_seq_pkg.sv
design/nmr_acq_pkg.sv
design/param_loader.sv
design/cpmg_sequencer.sv
design/iq_demod.sv
design/iq_decimator.sv
design/nmr_pulseprog_top.sv
bench/tb_nmr_pulseprog.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_nmr_pulseprog
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "sim: pass" || (echo "sim: fail"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
